// File: design/rt_eval_pkg.sv
`default_nettype none

package rt_eval_pkg;

  // Packet sequence number width, fixed by the BTH layout
  localparam int PSN_W = 24;

  // BTH opcode width
  localparam int OPCODE_W = 8;

  // AETH syndrome width
  localparam int SYNDROME_W = 8;

  typedef logic [PSN_W-1:0] psn_t;

  // RC opcodes the probe looks at
  // Other values may still show up on the bus and are ignored
  typedef enum logic [OPCODE_W-1:0] {
    WRITE_FIRST    = 8'h06,
    WRITE_MIDDLE   = 8'h07,
    WRITE_LAST     = 8'h08,
    WRITE_LAST_IMM = 8'h09,
    WRITE_ONLY     = 8'h0A,
    WRITE_ONLY_IMM = 8'h0B,
    ACK            = 8'h11
  } bth_opcode_e;

  // Syndrome bits 6:5 of a plain positive ACK
  localparam logic [1:0] ACK_CLASS_POSITIVE = 2'b00;

  // Transmit side BTH tap
  typedef struct packed {
    logic        valid;
    bth_opcode_e opcode;
    psn_t        psn;
  } tx_bth_t;

  // Receive side BTH plus AETH syndrome
  typedef struct packed {
    logic                  valid;
    bth_opcode_e           opcode;
    psn_t                  psn;
    logic [SYNDROME_W-1:0] syndrome;
  } rx_ack_t;

endpackage : rt_eval_pkg

`default_nettype wire

// File: design/cycle_stamp_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_stamp_counter #(
  parameter int STAMP_W = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  output logic [STAMP_W-1:0] stamp,
  output logic               restart
);

  // Start level from the previous cycle
  logic start_q;

  always_ff @(posedge clk) begin
    start_q <= start;
  end

  // One-cycle pulse on the rising edge of start
  // Holding start high gives no further pulses
  assign restart = start & ~start_q;

  // Free-running cycle counter
  // Stamp of a cycle is the value held during that cycle
  // Loads zero at the end of the restart cycle, wraps on overflow
  always_ff @(posedge clk) begin
    if (rst || restart) begin
      stamp <= '0;
    end else begin
      stamp <= stamp + STAMP_W'(1);
    end
  end

endmodule : cycle_stamp_counter

`default_nettype wire

// File: design/write_send_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module write_send_tracker #(
  parameter int STAMP_W = 64
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 restart,
  input  logic [STAMP_W-1:0]   stamp,
  input  rt_eval_pkg::tx_bth_t tx_bth,
  output rt_eval_pkg::psn_t    start_psn,
  output rt_eval_pkg::psn_t    finish_psn,
  output logic [STAMP_W-1:0]   start_stamp,
  output logic [STAMP_W-1:0]   end_stamp,
  output logic [STAMP_W-1:0]   send_time
);

  // Opcode classes
  logic is_opener;
  logic is_closer;

  // Start stamp the send time is measured from
  logic [STAMP_W-1:0] open_stamp;

  always_comb begin
    is_opener = 1'b0;
    is_closer = 1'b0;
    case (tx_bth.opcode)
      rt_eval_pkg::WRITE_FIRST: begin
        is_opener = 1'b1;
      end
      rt_eval_pkg::WRITE_LAST,
      rt_eval_pkg::WRITE_LAST_IMM: begin
        is_closer = 1'b1;
      end
      // Single-packet message opens and closes at once
      rt_eval_pkg::WRITE_ONLY,
      rt_eval_pkg::WRITE_ONLY_IMM: begin
        is_opener = 1'b1;
        is_closer = 1'b1;
      end
      // MIDDLE, ACK and foreign codes
      default: begin
        is_opener = 1'b0;
        is_closer = 1'b0;
      end
    endcase
  end

  // ONLY messages measure from their own stamp, so the duration is zero
  assign open_stamp = is_opener ? stamp : start_stamp;

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      start_psn   <= '0;
      finish_psn  <= '0;
      start_stamp <= '0;
      end_stamp   <= '0;
      send_time   <= '0;
    end else if (tx_bth.valid) begin
      // First packet of a message
      if (is_opener) begin
        start_psn   <= tx_bth.psn;
        start_stamp <= stamp;
      end
      // Last packet of a message
      if (is_closer) begin
        finish_psn <= tx_bth.psn;
        end_stamp  <= stamp;
        send_time  <= stamp - open_stamp;
      end
    end
  end

endmodule : write_send_tracker

`default_nettype wire

// File: design/ack_latency_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ack_latency_tracker #(
  parameter int STAMP_W = 64
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 restart,
  input  logic [STAMP_W-1:0]   stamp,
  input  rt_eval_pkg::rx_ack_t rx_ack,
  input  rt_eval_pkg::psn_t    start_psn,
  input  rt_eval_pkg::psn_t    finish_psn,
  input  logic [STAMP_W-1:0]   start_stamp,
  input  logic [STAMP_W-1:0]   end_stamp,
  output logic [STAMP_W-1:0]   first_latency,
  output logic [STAMP_W-1:0]   last_latency,
  output logic [STAMP_W-1:0]   total_time
);

  // Positive ACK seen this cycle
  logic ack_ok;

  // PSN matches against the recorded message bounds
  logic hit_first;
  logic hit_last;

  // Syndrome bits 6:5 carry the ACK class
  assign ack_ok = rx_ack.valid &&
                  (rx_ack.opcode == rt_eval_pkg::ACK) &&
                  (rx_ack.syndrome[6:5] == rt_eval_pkg::ACK_CLASS_POSITIVE);

  // PSNs are registered upstream
  // A WRITE seen this same cycle is not yet visible here
  assign hit_first = ack_ok && (rx_ack.psn == start_psn);
  assign hit_last  = ack_ok && (rx_ack.psn == finish_psn);

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      first_latency <= '0;
      last_latency  <= '0;
      total_time    <= '0;
    end else begin
      // ACK of the first packet
      if (hit_first) begin
        first_latency <= stamp - start_stamp;
      end
      // ACK of the last packet closes the message
      // Both hits fire together for a single-packet message
      if (hit_last) begin
        last_latency <= stamp - end_stamp;
        total_time   <= stamp - start_stamp;
      end
    end
  end

endmodule : ack_latency_tracker

`default_nettype wire

// File: design/roce_write_probe.sv
`timescale 1ns/1ps
`default_nettype none

module roce_write_probe #(
  parameter int STAMP_W = 64
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  rt_eval_pkg::tx_bth_t tx_bth,
  input  rt_eval_pkg::rx_ack_t rx_ack,
  output logic [STAMP_W-1:0]   send_time,
  output logic [STAMP_W-1:0]   total_time,
  output logic [STAMP_W-1:0]   first_latency,
  output logic [STAMP_W-1:0]   last_latency
);

  // Time base shared by both trackers
  logic [STAMP_W-1:0] stamp;
  logic               restart;

  // Recorded bounds of the last message
  rt_eval_pkg::psn_t  start_psn;
  rt_eval_pkg::psn_t  finish_psn;
  logic [STAMP_W-1:0] start_stamp;
  logic [STAMP_W-1:0] end_stamp;

  cycle_stamp_counter #(
    .STAMP_W (STAMP_W)
  ) u_counter (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .stamp   (stamp),
    .restart (restart)
  );

  // Transmit side
  write_send_tracker #(
    .STAMP_W (STAMP_W)
  ) u_send (
    .clk         (clk),
    .rst         (rst),
    .restart     (restart),
    .stamp       (stamp),
    .tx_bth      (tx_bth),
    .start_psn   (start_psn),
    .finish_psn  (finish_psn),
    .start_stamp (start_stamp),
    .end_stamp   (end_stamp),
    .send_time   (send_time)
  );

  // Receive side
  ack_latency_tracker #(
    .STAMP_W (STAMP_W)
  ) u_ack (
    .clk           (clk),
    .rst           (rst),
    .restart       (restart),
    .stamp         (stamp),
    .rx_ack        (rx_ack),
    .start_psn     (start_psn),
    .finish_psn    (finish_psn),
    .start_stamp   (start_stamp),
    .end_stamp     (end_stamp),
    .first_latency (first_latency),
    .last_latency  (last_latency),
    .total_time    (total_time)
  );

endmodule : roce_write_probe

`default_nettype wire

// File: include/rt_eval_tb_util.svh
`ifndef RT_EVAL_TB_UTIL_SVH
`define RT_EVAL_TB_UTIL_SVH

// Included inside the testbench module
// Expects clk, tx_bth, rx_ack and lfsr (logic [31:0]) in that scope

localparam logic [31:0] LFSR_SEED = 32'h4dfd;

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// Takes n fresh bits, one step per bit
task automatic lfsr_take(input int n, output logic [31:0] bits);
  bits = '0;
  repeat (n) begin
    lfsr = lfsr_step(lfsr);
    bits = {bits[30:0], lfsr[0]};
  end
endtask

// Call right after a rising edge
// Header is valid for the cycle that follows, back-to-back calls chain
task automatic drive_tx(input logic [7:0] op, input rt_eval_pkg::psn_t psn);
  tx_bth <= '{valid: 1'b1, opcode: rt_eval_pkg::bth_opcode_e'(op), psn: psn};
  @(posedge clk);
  tx_bth.valid <= 1'b0;
endtask

task automatic drive_rx(input logic [7:0] op, input rt_eval_pkg::psn_t psn,
                        input logic [7:0] syndrome);
  rx_ack <= '{valid: 1'b1, opcode: rt_eval_pkg::bth_opcode_e'(op), psn: psn,
              syndrome: syndrome};
  @(posedge clk);
  rx_ack.valid <= 1'b0;
endtask

// Idle gap of n cycles
task automatic idle(input int n);
  repeat (n) @(posedge clk);
endtask

// Stamp seen in cycle now_cyc after a start edge in cycle edge_cyc
function automatic logic [63:0] ref_stamp(input longint unsigned now_cyc,
                                          input longint unsigned edge_cyc);
  return 64'(now_cyc - edge_cyc - 1);
endfunction

// Expected result between two header cycles
function automatic logic [63:0] ref_elapsed(input longint unsigned from_cyc,
                                            input longint unsigned to_cyc);
  return 64'(to_cyc - from_cyc);
endfunction

`endif

// File: bench/rt_eval_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rt_eval_tb;

  localparam int STAMP_W = 64;

  // Random gaps and MIDDLE counts come from 3 LFSR bits
  localparam longint unsigned GAP_MAX = 64'd7;
  localparam longint unsigned MID_MAX = 64'd7;

  // Worst-case cycles per sequence
  localparam longint unsigned MSG_CYC  = (MID_MAX + 64'd2) * (GAP_MAX + 64'd1);
  localparam longint unsigned ACK_CYC  = 64'd3 * (GAP_MAX + 64'd1);
  localparam longint unsigned NEG_CYC  = 64'd8 * (GAP_MAX + 64'd1);
  localparam longint unsigned ONLY_CYC = 64'd4 * (GAP_MAX + 64'd1);
  localparam longint unsigned TIMEOUT_CYCLES =
    64'd2 * (MSG_CYC + ACK_CYC) + NEG_CYC + ONLY_CYC + 64'd16 + 64'd64;

  logic clk;
  logic rst;
  logic start;
  rt_eval_pkg::tx_bth_t tx_bth;
  rt_eval_pkg::rx_ack_t rx_ack;

  logic [STAMP_W-1:0] send_time;
  logic [STAMP_W-1:0] total_time;
  logic [STAMP_W-1:0] first_latency;
  logic [STAMP_W-1:0] last_latency;

  // LFSR state, stepped by the helpers in the header
  logic [31:0] lfsr;

  // Cycle index, reads as the current cycle right after a rising edge
  longint unsigned cyc;

  // Expected results, updated on the same edge as the DUT registers
  logic [STAMP_W-1:0] exp_send;
  logic [STAMP_W-1:0] exp_total;
  logic [STAMP_W-1:0] exp_first;
  logic [STAMP_W-1:0] exp_last;

  // Cycle of the last start edge and of the current message bounds
  longint unsigned edge_cyc;
  longint unsigned first_cyc;
  longint unsigned last_cyc;
  rt_eval_pkg::psn_t msg_first_psn;
  rt_eval_pkg::psn_t msg_last_psn;

  int value_errors = 0;
  int clear_errors = 0;

  `include "rt_eval_tb_util.svh"

  roce_write_probe #(
    .STAMP_W (STAMP_W)
  ) dut (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .tx_bth        (tx_bth),
    .rx_ack        (rx_ack),
    .send_time     (send_time),
    .total_time    (total_time),
    .first_latency (first_latency),
    .last_latency  (last_latency)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    if (rst) begin
      cyc <= 64'd0;
    end else begin
      cyc <= cyc + 64'd1;
    end
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d value, %0d clear", value_errors, clear_errors);
      $display("** FAIL **");
      $finish;
    end
  end

  // Each result tracks its expected value every cycle
  send_time_ok: assert property (@(posedge clk) disable iff (rst) send_time == exp_send)
    else begin
      value_errors++;
      $display("ERR t=%0t send_time %0d expected %0d", $time,
               $sampled(send_time), $sampled(exp_send));
    end

  total_time_ok: assert property (@(posedge clk) disable iff (rst) total_time == exp_total)
    else begin
      value_errors++;
      $display("ERR t=%0t total_time %0d expected %0d", $time,
               $sampled(total_time), $sampled(exp_total));
    end

  first_latency_ok: assert property (@(posedge clk) disable iff (rst)
                                     first_latency == exp_first)
    else begin
      value_errors++;
      $display("ERR t=%0t first_latency %0d expected %0d", $time,
               $sampled(first_latency), $sampled(exp_first));
    end

  last_latency_ok: assert property (@(posedge clk) disable iff (rst)
                                    last_latency == exp_last)
    else begin
      value_errors++;
      $display("ERR t=%0t last_latency %0d expected %0d", $time,
               $sampled(last_latency), $sampled(exp_last));
    end

  // One cycle after a start edge everything reads zero
  cleared_after_edge: assert property (@(posedge clk) disable iff (rst)
      ($past(start) && !$past(start, 2)) |->
      (send_time == '0 && total_time == '0 && first_latency == '0 && last_latency == '0))
    else begin
      clear_errors++;
      $display("ERR t=%0t results not cleared after start edge", $time);
    end

  // Start edge in the current cycle, start stays high
  task automatic raise_start();
    start <= 1'b1;
    edge_cyc = cyc;
    @(posedge clk);
    exp_send  <= '0;
    exp_total <= '0;
    exp_first <= '0;
    exp_last  <= '0;
  endtask

  task automatic drop_start();
    start <= 1'b0;
    @(posedge clk);
  endtask

  // Random idle gap of 0 to 7 cycles
  task automatic pause_random();
    logic [31:0] r;
    lfsr_take(3, r);
    idle(int'(r[2:0]));
  endtask

  // FIRST, random MIDDLEs with gaps, then LAST or LAST_IMM
  task automatic send_multi_message(input rt_eval_pkg::psn_t base);
    logic [31:0] r;
    logic [7:0] closer;
    int n_mid;
    int i;
    lfsr_take(3, r);
    n_mid = int'(r[2:0]);
    lfsr_take(1, r);
    closer = r[0] ? rt_eval_pkg::WRITE_LAST_IMM : rt_eval_pkg::WRITE_LAST;
    msg_first_psn = base;
    msg_last_psn = base + rt_eval_pkg::psn_t'(n_mid + 1);
    first_cyc = cyc;
    drive_tx(rt_eval_pkg::WRITE_FIRST, base);
    for (i = 1; i <= n_mid; i++) begin
      pause_random();
      drive_tx(rt_eval_pkg::WRITE_MIDDLE, base + rt_eval_pkg::psn_t'(i));
    end
    pause_random();
    last_cyc = cyc;
    drive_tx(closer, msg_last_psn);
    // Duration is the stamp difference between closer and FIRST
    exp_send <= ref_stamp(last_cyc, edge_cyc) - ref_stamp(first_cyc, edge_cyc);
  endtask

  // Single packet opens and closes the message
  task automatic send_only_message(input logic [7:0] op, input rt_eval_pkg::psn_t psn);
    msg_first_psn = psn;
    msg_last_psn = psn;
    first_cyc = cyc;
    last_cyc = cyc;
    drive_tx(op, psn);
    exp_send <= '0;
  endtask

  // Positive ACK, syndrome bits 6:5 clear and the rest random
  task automatic ack_psn(input rt_eval_pkg::psn_t psn);
    logic [31:0] r;
    longint unsigned ack_cyc;
    lfsr_take(8, r);
    ack_cyc = cyc;
    drive_rx(rt_eval_pkg::ACK, psn, r[7:0] & 8'h9F);
    if (psn == msg_first_psn) begin
      exp_first <= ref_elapsed(first_cyc, ack_cyc);
    end
    if (psn == msg_last_psn) begin
      exp_last  <= ref_elapsed(last_cyc, ack_cyc);
      exp_total <= ref_elapsed(first_cyc, ack_cyc);
    end
  endtask

  task automatic ack_in_random_order();
    logic [31:0] r;
    lfsr_take(1, r);
    pause_random();
    if (r[0]) begin
      ack_psn(msg_last_psn);
      pause_random();
      ack_psn(msg_first_psn);
    end else begin
      ack_psn(msg_first_psn);
      pause_random();
      ack_psn(msg_last_psn);
    end
  endtask

  // Headers that must leave every result alone
  task automatic check_ignored_headers();
    logic [31:0] r;
    logic [7:0] op;
    // NAK class, then class 11
    lfsr_take(8, r);
    pause_random();
    drive_rx(rt_eval_pkg::ACK, msg_first_psn, r[7:0] | 8'h20);
    pause_random();
    drive_rx(rt_eval_pkg::ACK, msg_last_psn, (r[7:0] & 8'h9F) | 8'h60);
    // Non-ACK receive opcode on a matching PSN
    lfsr_take(8, r);
    op = r[7:0];
    if (op == 8'h11) begin
      op = 8'h12;
    end
    pause_random();
    drive_rx(op, msg_last_psn, 8'h00);
    // PSN outside the message
    pause_random();
    drive_rx(rt_eval_pkg::ACK, msg_first_psn - 24'd1, 8'h00);
    // Foreign transmit opcode, kept out of the WRITE range
    lfsr_take(8, r);
    op = r[7:0];
    if (op >= 8'h06 && op <= 8'h0B) begin
      op = op ^ 8'h80;
    end
    lfsr_take(24, r);
    pause_random();
    drive_tx(op, r[23:0]);
    pause_random();
    drive_tx(rt_eval_pkg::WRITE_MIDDLE, msg_last_psn + 24'd1);
    // Recorded bounds still intact
    pause_random();
    ack_psn(msg_last_psn);
  endtask

  initial begin
    logic [31:0] r;
    lfsr = LFSR_SEED;
    rst <= 1'b1;
    start <= 1'b0;
    tx_bth <= '0;
    rx_ack <= '0;
    exp_send <= '0;
    exp_total <= '0;
    exp_first <= '0;
    exp_last <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    idle(2);

    // Start held high across a whole message and its ACKs
    raise_start();
    lfsr_take(24, r);
    send_multi_message(r[23:0]);
    ack_in_random_order();
    pause_random();
    drop_start();
    check_ignored_headers();

    // WRITE_ONLY and WRITE_ONLY_IMM
    raise_start();
    drop_start();
    lfsr_take(24, r);
    pause_random();
    send_only_message(rt_eval_pkg::WRITE_ONLY, r[23:0]);
    pause_random();
    ack_psn(msg_last_psn);
    lfsr_take(24, r);
    pause_random();
    send_only_message(rt_eval_pkg::WRITE_ONLY_IMM, r[23:0]);
    pause_random();
    ack_psn(msg_last_psn);

    // Second multi-packet message on a cleared counter
    raise_start();
    drop_start();
    lfsr_take(24, r);
    send_multi_message(r[23:0]);
    ack_in_random_order();
    idle(3);

    $display("Errors: %0d value, %0d clear", value_errors, clear_errors);
    if (value_errors == 0 && clear_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : rt_eval_tb

`default_nettype wire

// File: all.f
+incdir+include
design/rt_eval_pkg.sv
design/cycle_stamp_counter.sv
design/write_send_tracker.sv
design/ack_latency_tracker.sv
design/roce_write_probe.sv
bench/rt_eval_tb.sv

// File: Makefile
TOP := rt_eval_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)
	verilator --lint-only design/rt_eval_pkg.sv design/cycle_stamp_counter.sv \
	  design/write_send_tracker.sv design/ack_latency_tracker.sv \
	  design/roce_write_probe.sv --top-module roce_write_probe

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) \
	  -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
